//--- src/core_pkg.sv
// XLEN, op_e, decoded_t, Wishbone ibus/dbus structs, mem_size_e and mem_req_t
package core_pkg;

  localparam int unsigned XLEN = 64;

  typedef enum logic [4:0] {
    op_illegal,
    op_lui,
    op_auipc,
    op_jal,
    op_jalr,
    op_bne,
    op_lw,
    op_lbu,
    op_ld,
    op_sh,
    op_sd,
    op_addi,
    op_sltiu,
    op_addiw,
    op_add,
    op_sub,
    op_addw,
    op_sllw,
    op_srai,
    op_ebreak
  } op_e;

  typedef struct packed {
    op_e             op;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [5:0]      shamt;
    logic [XLEN-1:0] imm;    // sign-extended per format
  } decoded_t;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic [31:0] adr;
  } ibus_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } ibus_rsp_t;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [63:0] dat;
    logic [7:0]  sel;
  } dbus_req_t;

  typedef struct packed {
    logic        ack;
    logic [63:0] dat;
  } dbus_rsp_t;

  typedef enum logic [1:0] {
    size_byte,
    size_half,
    size_word,
    size_double
  } mem_size_e;

  typedef struct packed {
    logic        valid;
    logic        we;
    mem_size_e   size;
    logic        unsigned_load;
    logic [31:0] addr;
    logic [63:0] wdata;
  } mem_req_t;

endpackage

//--- src/inst_fetch.sv
// program counter and Wishbone classic instruction-bus read master
`timescale 1ns/1ps

module inst_fetch import core_pkg::*; #(
  parameter int unsigned ADDR_W   = 32,
  parameter logic [63:0] RESET_PC = 64'h0
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        redirect_valid,
  input  logic [63:0] next_pc,
  input  ibus_rsp_t   ibus_rsp,
  input  logic        inst_ready,
  output ibus_req_t   ibus,
  output logic        inst_valid,
  output logic [31:0] inst,
  output logic [63:0] pc
);

  typedef enum logic [1:0] {
    st_req,
    st_hold,
    st_wait
  } fetch_state_e;

  fetch_state_e state;
  logic         cyc_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_req;
      cyc_q <= 1'b0;
      pc    <= RESET_PC;
    end else begin
      case (state)
        st_req: begin
          if (!cyc_q) begin
            cyc_q <= 1'b1;               // first request after reset
          end else if (ibus_rsp.ack) begin
            cyc_q <= 1'b0;
            state <= st_hold;
          end
        end
        st_hold: begin
          if (inst_ready) begin
            state <= st_wait;            // handed to execute
          end
        end
        st_wait: begin
          if (redirect_valid) begin
            pc    <= next_pc;
            cyc_q <= 1'b1;               // next read starts right away
            state <= st_req;
          end
        end
        default: state <= st_wait;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cyc_q && ibus_rsp.ack) begin
      inst <= ibus_rsp.dat;
    end
  end

  always_comb begin
    ibus.cyc = cyc_q;
    ibus.stb = cyc_q;
    ibus.adr = 32'(pc[ADDR_W-1:0]);     // zero-extended onto adr
  end

  assign inst_valid = (state == st_hold);

endmodule

//--- src/inst_decode.sv
// combinational RV64 subset decoder with immediate generation
`timescale 1ns/1ps

module inst_decode import core_pkg::*; (
  input  logic [31:0] inst,
  output decoded_t    dec
);

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  op_e             op;

  // all immediates take their sign from bit 31
  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'h000};
  assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    op = op_illegal;
    if (inst == 32'h0010_0073) begin
      op = op_ebreak;
    end else begin
      casez ({inst[31:25], inst[14:12], inst[6:0]})  // funct7, funct3, opcode
        17'b???????_???_0110111: op = op_lui;
        17'b???????_???_0010111: op = op_auipc;
        17'b???????_???_1101111: op = op_jal;
        17'b???????_000_1100111: op = op_jalr;
        17'b???????_001_1100011: op = op_bne;
        17'b???????_010_0000011: op = op_lw;
        17'b???????_100_0000011: op = op_lbu;
        17'b???????_011_0000011: op = op_ld;
        17'b???????_001_0100011: op = op_sh;
        17'b???????_011_0100011: op = op_sd;
        17'b???????_000_0010011: op = op_addi;
        17'b???????_011_0010011: op = op_sltiu;
        17'b???????_000_0011011: op = op_addiw;
        17'b0000000_000_0110011: op = op_add;
        17'b0100000_000_0110011: op = op_sub;
        17'b0000000_000_0111011: op = op_addw;
        17'b0000000_001_0111011: op = op_sllw;
        17'b010000?_101_0010011: op = op_srai;  // bit 25 is shamt[5]
        default:                 op = op_illegal;
      endcase
    end
  end

  always_comb begin
    dec.op    = op;
    dec.rd    = inst[11:7];
    dec.rs1   = inst[19:15];
    dec.rs2   = inst[24:20];
    dec.shamt = inst[25:20];
    case (op)
      op_jalr, op_lw, op_lbu, op_ld,
      op_addi, op_sltiu, op_addiw: dec.imm = imm_i;
      op_sh, op_sd:                dec.imm = imm_s;
      op_bne:                      dec.imm = imm_b;
      op_lui, op_auipc:            dec.imm = imm_u;
      op_jal:                      dec.imm = imm_j;
      default:                     dec.imm = '0;     // R-type and srai
    endcase
  end

endmodule

//--- src/reg_file.sv
// 32 x XLEN integer registers, two read ports and one write port
`timescale 1ns/1ps

module reg_file import core_pkg::*; (
  input  logic            clk,
  input  logic            arst_n,
  input  logic [4:0]      rs1,
  input  logic [4:0]      rs2,
  input  logic            we,
  input  logic [4:0]      waddr,
  input  logic [XLEN-1:0] wdata,
  output logic [XLEN-1:0] rdata1,
  output logic [XLEN-1:0] rdata2
);

  logic [XLEN-1:0] regs [32];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != 5'd0)) begin  // x0 stays zero
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = regs[rs1];
  assign rdata2 = regs[rs2];

endmodule

//--- src/exec_unit.sv
// execute sequencer with ALU, next-pc logic, writeback, memory issue and halt
`timescale 1ns/1ps

module exec_unit import core_pkg::*; (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            inst_valid,
  input  logic [63:0]     pc,
  input  decoded_t        dec,
  input  logic [XLEN-1:0] rdata1,
  input  logic [XLEN-1:0] rdata2,
  input  logic            mem_done,
  input  logic [63:0]     mem_rdata,
  output logic            inst_ready,
  output logic [4:0]      rs1,
  output logic [4:0]      rs2,
  output logic            we,
  output logic [4:0]      waddr,
  output logic [XLEN-1:0] wdata,
  output mem_req_t        mem_req,
  output logic            redirect_valid,
  output logic [63:0]     next_pc,
  output logic            halted
);

  typedef enum logic [1:0] {
    st_idle,
    st_exec,
    st_wb,
    st_halt
  } exec_state_e;

  exec_state_e     state;
  decoded_t        dec_q;
  logic [63:0]     pc_q;
  logic [XLEN-1:0] a_q;
  logic [XLEN-1:0] b_q;
  logic [63:0]     ld_q;
  logic [XLEN-1:0] alu_res;
  logic            is_load;
  logic            is_store;
  logic            writes_rd;

  function automatic logic [63:0] sext32(input logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  assign is_load   = dec_q.op inside {op_lw, op_lbu, op_ld};
  assign is_store  = dec_q.op inside {op_sh, op_sd};
  assign writes_rd = !(dec_q.op inside {op_bne, op_sh, op_sd, op_ebreak, op_illegal});

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (inst_valid) begin
            state <= (dec.op inside {op_ebreak, op_illegal}) ? st_halt : st_exec;
          end
        end
        st_exec: begin
          if (!(is_load || is_store)) begin
            state <= st_idle;              // retired this cycle
          end else if (mem_done) begin
            state <= st_wb;
          end
        end
        st_wb:   state <= st_idle;
        default: state <= st_halt;         // stays until reset
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (inst_ready && inst_valid) begin
      dec_q <= dec;
      pc_q  <= pc;
      a_q   <= rdata1;
      b_q   <= rdata2;
    end
    if (mem_done) begin
      ld_q <= mem_rdata;
    end
  end

  always_comb begin
    case (dec_q.op)
      op_lui:   alu_res = dec_q.imm;
      op_auipc: alu_res = pc_q + dec_q.imm;
      op_jal,
      op_jalr:  alu_res = pc_q + 64'd4;       // link value
      op_addi:  alu_res = a_q + dec_q.imm;
      op_sltiu: alu_res = {63'd0, (a_q < dec_q.imm)};
      op_addiw: alu_res = sext32(a_q[31:0] + dec_q.imm[31:0]);
      op_add:   alu_res = a_q + b_q;
      op_sub:   alu_res = a_q - b_q;
      op_addw:  alu_res = sext32(a_q[31:0] + b_q[31:0]);
      op_sllw:  alu_res = sext32(a_q[31:0] << b_q[4:0]);
      op_srai:  alu_res = $signed(a_q) >>> dec_q.shamt;
      default:  alu_res = a_q + dec_q.imm;    // load/store address
    endcase
  end

  always_comb begin
    case (dec_q.op)
      op_jal:  next_pc = pc_q + dec_q.imm;
      op_jalr: next_pc = (a_q + dec_q.imm) & ~64'd1;
      op_bne:  next_pc = (a_q != b_q) ? pc_q + dec_q.imm : pc_q + 64'd4;
      default: next_pc = pc_q + 64'd4;
    endcase
  end

  always_comb begin
    mem_req.valid         = (state == st_exec) && (is_load || is_store);
    mem_req.we            = is_store;
    mem_req.unsigned_load = (dec_q.op == op_lbu);
    mem_req.addr          = 32'(alu_res);
    mem_req.wdata         = b_q;
    case (dec_q.op)
      op_lbu:       mem_req.size = size_byte;
      op_sh:        mem_req.size = size_half;
      op_lw:        mem_req.size = size_word;
      default:      mem_req.size = size_double;
    endcase
  end

  assign inst_ready     = (state == st_idle);
  assign rs1            = dec.rs1;          // read at the handshake
  assign rs2            = dec.rs2;
  assign redirect_valid = ((state == st_exec) && !(is_load || is_store)) || (state == st_wb);
  assign we             = redirect_valid && writes_rd;
  assign waddr          = dec_q.rd;
  assign wdata          = is_load ? ld_q : alu_res;
  assign halted         = (state == st_halt);

endmodule

//--- src/load_store.sv
// Wishbone classic data-bus master with lane select and load extension
`timescale 1ns/1ps

module load_store import core_pkg::*; #(
  parameter int unsigned ADDR_W = 32
) (
  input  logic        clk,
  input  logic        arst_n,
  input  mem_req_t    mem_req,
  input  dbus_rsp_t   dbus_rsp,
  output dbus_req_t   dbus,
  output logic        mem_done,
  output logic [63:0] mem_rdata
);

  logic [ADDR_W-1:0] addr;
  logic [2:0]        off;
  logic [7:0]        size_mask;
  logic [63:0]       lane_data;
  logic [63:0]       load_ext;
  logic              done_q;

  assign addr = mem_req.addr[ADDR_W-1:0];
  assign off  = addr[2:0];

  always_comb begin
    case (mem_req.size)
      size_byte: size_mask = 8'h01;
      size_half: size_mask = 8'h03;
      size_word: size_mask = 8'h0f;
      default:   size_mask = 8'hff;
    endcase
    dbus.cyc = mem_req.valid && !done_q;   // dropped in the done cycle
    dbus.stb = mem_req.valid && !done_q;
    dbus.we  = mem_req.we;
    dbus.adr = 32'({addr[ADDR_W-1:3], 3'b000});
    dbus.dat = mem_req.wdata << {off, 3'b000};
    dbus.sel = size_mask << off;
  end

  assign lane_data = dbus_rsp.dat >> {off, 3'b000};

  always_comb begin
    case (mem_req.size)
      size_byte: load_ext = mem_req.unsigned_load ? {56'd0, lane_data[7:0]}
                                                  : {{56{lane_data[7]}}, lane_data[7:0]};
      size_half: load_ext = mem_req.unsigned_load ? {48'd0, lane_data[15:0]}
                                                  : {{48{lane_data[15]}}, lane_data[15:0]};
      size_word: load_ext = mem_req.unsigned_load ? {32'd0, lane_data[31:0]}
                                                  : {{32{lane_data[31]}}, lane_data[31:0]};
      default:   load_ext = lane_data;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      done_q <= 1'b0;
    end else begin
      done_q <= dbus.cyc && dbus_rsp.ack;  // one-cycle pulse
    end
  end

  always_ff @(posedge clk) begin
    if (dbus.cyc && dbus_rsp.ack) begin
      mem_rdata <= load_ext;
    end
  end

  assign mem_done = done_q;

endmodule

//--- src/rv_core_top.sv
// core top level wiring fetch, decode, register file, execute and load/store
`timescale 1ns/1ps

module rv_core_top import core_pkg::*; #(
  parameter int unsigned ADDR_W   = 32,
  parameter logic [63:0] RESET_PC = 64'h0
) (
  input  logic      clk,
  input  logic      arst_n,
  input  ibus_rsp_t ibus_rsp,
  input  dbus_rsp_t dbus_rsp,
  output ibus_req_t ibus,
  output dbus_req_t dbus,
  output logic      halted
);

  logic            inst_valid;
  logic            inst_ready;
  logic [31:0]     inst;
  logic [63:0]     pc;
  logic            redirect_valid;
  logic [63:0]     next_pc;
  decoded_t        dec;
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [XLEN-1:0] rdata1;
  logic [XLEN-1:0] rdata2;
  logic            rf_we;
  logic [4:0]      waddr;
  logic [XLEN-1:0] wdata;
  mem_req_t        mem_req;
  logic            mem_done;
  logic [63:0]     mem_rdata;

  inst_fetch #(
    .ADDR_W   (ADDR_W),
    .RESET_PC (RESET_PC)
  ) i_inst_fetch (
    .clk            (clk),
    .arst_n         (arst_n),
    .redirect_valid (redirect_valid),
    .next_pc        (next_pc),
    .ibus_rsp       (ibus_rsp),
    .inst_ready     (inst_ready),
    .ibus           (ibus),
    .inst_valid     (inst_valid),
    .inst           (inst),
    .pc             (pc)
  );

  inst_decode i_inst_decode (
    .inst (inst),
    .dec  (dec)
  );

  reg_file i_reg_file (
    .clk    (clk),
    .arst_n (arst_n),
    .rs1    (rs1),
    .rs2    (rs2),
    .we     (rf_we),
    .waddr  (waddr),
    .wdata  (wdata),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  exec_unit i_exec_unit (
    .clk            (clk),
    .arst_n         (arst_n),
    .inst_valid     (inst_valid),
    .pc             (pc),
    .dec            (dec),
    .rdata1         (rdata1),
    .rdata2         (rdata2),
    .mem_done       (mem_done),
    .mem_rdata      (mem_rdata),
    .inst_ready     (inst_ready),
    .rs1            (rs1),
    .rs2            (rs2),
    .we             (rf_we),
    .waddr          (waddr),
    .wdata          (wdata),
    .mem_req        (mem_req),
    .redirect_valid (redirect_valid),
    .next_pc        (next_pc),
    .halted         (halted)
  );

  load_store #(
    .ADDR_W (ADDR_W)
  ) i_load_store (
    .clk       (clk),
    .arst_n    (arst_n),
    .mem_req   (mem_req),
    .dbus_rsp  (dbus_rsp),
    .dbus      (dbus),
    .mem_done  (mem_done),
    .mem_rdata (mem_rdata)
  );

endmodule

//--- tests/wb_mem_model.sv
// shared memory model with Wishbone classic instruction and data ports and random ack delay
`timescale 1ns/1ps

module wb_mem_model import core_pkg::*; #(
  parameter int unsigned MEM_WORDS = 512
) (
  input  logic      clk,
  input  logic      arst_n,
  input  ibus_req_t ibus,
  input  dbus_req_t dbus,
  output ibus_rsp_t ibus_rsp,
  output dbus_rsp_t dbus_rsp
);

  logic [63:0] mem [MEM_WORDS];
  logic [1:0]  iwait;
  logic [1:0]  dwait;

  // every word differs, so a stray fetch decodes as illegal
  task automatic fill_pattern();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] <= {32'(i * 8 + 4) | 32'hf000_0000, 32'(i * 8) | 32'hf000_0000};
    end
  endtask

  task automatic write_inst(input logic [31:0] addr, input logic [31:0] word);
    if (addr[2]) begin
      mem[addr[11:3]][63:32] <= word;
    end else begin
      mem[addr[11:3]][31:0] <= word;
    end
  endtask

  task automatic write_dword(input logic [31:0] addr, input logic [63:0] data);
    mem[addr[11:3]] <= data;
  endtask

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ibus_rsp <= '0;
      iwait    <= 2'd0;
    end else if (ibus_rsp.ack) begin
      ibus_rsp.ack <= 1'b0;                       // master drops cyc next
      iwait        <= 2'($urandom_range(3, 0));
    end else if (ibus.cyc && ibus.stb) begin
      if (iwait == 2'd0) begin
        ibus_rsp.ack <= 1'b1;
        ibus_rsp.dat <= ibus.adr[2] ? mem[ibus.adr[11:3]][63:32] : mem[ibus.adr[11:3]][31:0];
      end else begin
        iwait <= iwait - 2'd1;
      end
    end
  end

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dbus_rsp <= '0;
      dwait    <= 2'd0;
    end else if (dbus_rsp.ack) begin
      dbus_rsp.ack <= 1'b0;
      dwait        <= 2'($urandom_range(3, 0));
    end else if (dbus.cyc && dbus.stb) begin
      if (dwait == 2'd0) begin
        dbus_rsp.ack <= 1'b1;
        if (dbus.we) begin
          for (int b = 0; b < 8; b++) begin
            if (dbus.sel[b]) begin
              mem[dbus.adr[11:3]][b*8 +: 8] <= dbus.dat[b*8 +: 8];  // byte lanes
            end
          end
        end else begin
          dbus_rsp.dat <= mem[dbus.adr[11:3]];
        end
      end else begin
        dwait <= dwait - 2'd1;
      end
    end
  end

endmodule

//--- tests/rv_core_tb.sv
// testbench top with clock, reset, program loading, directed tests and compare tasks
`timescale 1ns/1ps

module rv_core_tb import core_pkg::*;;

  localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP_IMM32 = 7'b0011011;
  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_OP32     = 7'b0111011;
  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
  localparam logic [6:0] OPC_JALR     = 7'b1100111;
  localparam logic [31:0] EBREAK      = 32'h0010_0073;

  logic        clk;
  logic        arst_n;
  ibus_req_t   ibus;
  ibus_rsp_t   ibus_rsp;
  dbus_req_t   dbus;
  dbus_rsp_t   dbus_rsp;
  logic        halted;
  logic [31:0] prog [$];
  dbus_req_t   wr_log [$];
  int          fetch_cnt;

  rv_core_top #(
    .ADDR_W   (32),
    .RESET_PC (64'h0)
  ) i_rv_core_top (
    .clk      (clk),
    .arst_n   (arst_n),
    .ibus_rsp (ibus_rsp),
    .dbus_rsp (dbus_rsp),
    .ibus     (ibus),
    .dbus     (dbus),
    .halted   (halted)
  );

  wb_mem_model i_mem (
    .clk      (clk),
    .arst_n   (arst_n),
    .ibus     (ibus),
    .dbus     (dbus),
    .ibus_rsp (ibus_rsp),
    .dbus_rsp (dbus_rsp)
  );

  always #4 clk = ~clk;

  // acknowledged data writes in bus order, and instruction fetches
  always @(posedge clk) begin
    if (dbus.cyc && dbus.stb && dbus.we && dbus_rsp.ack) begin
      wr_log.push_back(dbus);
    end
    if (ibus.cyc && ibus.stb && ibus_rsp.ack) begin
      fetch_cnt++;
    end
  end

  function automatic logic [31:0] itype(input logic [31:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm[11:0], rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] stype(input logic [31:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] btype(input logic [31:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jtype(input logic [31:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] sd(input logic [4:0] rs2, input logic [31:0] off);
    return stype(off, rs2, 5'd0, 3'b011);
  endfunction

  function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [31:0] imm);
    return itype(imm, rs1, 3'b000, rd, OPC_OP_IMM);
  endfunction

  task automatic report_error(input string line);
    $display("%s", line);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic compare_word(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      report_error($sformatf("Fail at %0t: %s expected %h got %h", $time, what, exp, act));
    end
  endtask

  task automatic compare_halt(input logic exp);
    if (halted !== exp) begin
      report_error($sformatf("Fail at %0t: halted expected %b got %b", $time, exp, halted));
    end
  endtask

  task automatic compare_dbus_write(input int idx, input dbus_req_t exp);
    dbus_req_t   act;
    logic [63:0] mask;
    if (idx >= wr_log.size()) begin
      report_error($sformatf("data bus write number %0d never happened", idx));
    end
    act = wr_log[idx];
    for (int b = 0; b < 8; b++) begin
      mask[b*8 +: 8] = {8{exp.sel[b]}};   // only enabled lanes carry data
    end
    compare_word($sformatf("write %0d adr", idx), 64'(exp.adr), 64'(act.adr));
    compare_word($sformatf("write %0d sel", idx), 64'(exp.sel), 64'(act.sel));
    compare_word($sformatf("write %0d dat", idx), exp.dat & mask, act.dat & mask);
  endtask

  task automatic expect_write(input int idx, input logic [31:0] adr, input logic [7:0] sel,
                              input logic [63:0] dat);
    dbus_req_t exp;
    exp     = '0;
    exp.cyc = 1'b1;
    exp.stb = 1'b1;
    exp.we  = 1'b1;
    exp.adr = adr;
    exp.sel = sel;
    exp.dat = dat;
    compare_dbus_write(idx, exp);
  endtask

  task automatic check_counts(input int writes, input int max_fetches);
    compare_word("data write count", 64'(writes), 64'(wr_log.size()));
    if (fetch_cnt > max_fetches) begin
      report_error($sformatf("Fail at %0t: %0d fetches, at most %0d expected",
                             $time, fetch_cnt, max_fetches));
    end
  endtask

  task automatic hold_reset_and_load();
    @(posedge clk);
    arst_n <= 1'b0;
    i_mem.fill_pattern();
    for (int k = 0; k < prog.size(); k++) begin
      i_mem.write_inst(32'(k * 4), prog[k]);
    end
    wr_log.delete();
    fetch_cnt = 0;
  endtask

  task automatic release_reset();
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
  endtask

  task automatic wait_for_halt();
    int i;
    for (i = 0; i < 3000; i++) begin
      @(posedge clk);
      if (halted) begin
        break;
      end
    end
    if (!halted) begin
      report_error("timeout: the core never raised halted");
    end
  endtask

  task automatic test_arith();
    prog = '{addi(1, 0, -5), addi(2, 0, 100),
             rtype(7'h00, 2, 1, 3'b000, 3, OPC_OP), rtype(7'h20, 2, 1, 3'b000, 4, OPC_OP),
             {20'h80000, 5'd5, OPC_LUI}, {20'h00001, 5'd6, OPC_AUIPC},
             itype(32'h401, 1, 3'b101, 7, OPC_OP_IMM),           // srai x7, x1, 1
             itype(-1, 2, 3'b011, 8, OPC_OP_IMM), itype(5, 1, 3'b011, 9, OPC_OP_IMM),
             sd(3, 'h400), sd(4, 'h408), sd(5, 'h410), sd(6, 'h418),
             sd(7, 'h420), sd(8, 'h428), sd(9, 'h430), EBREAK};
    hold_reset_and_load();
    release_reset();
    wait_for_halt();
    expect_write(0, 32'h400, 8'hff, 64'd95);
    expect_write(1, 32'h408, 8'hff, 64'hffff_ffff_ffff_ff97);
    expect_write(2, 32'h410, 8'hff, 64'hffff_ffff_8000_0000);
    expect_write(3, 32'h418, 8'hff, 64'h1014);        // auipc at pc 20
    expect_write(4, 32'h420, 8'hff, 64'hffff_ffff_ffff_fffd);
    expect_write(5, 32'h428, 8'hff, 64'd1);
    expect_write(6, 32'h430, 8'hff, 64'd0);
    check_counts(7, 17);
  endtask

  task automatic test_wforms();
    prog = '{{20'h7ffff, 5'd2, OPC_LUI}, addi(2, 2, 2047), addi(2, 2, 2047),
             itype(3, 2, 3'b000, 3, OPC_OP_IMM32),              // addiw crosses bit 31
             rtype(7'h00, 2, 2, 3'b000, 4, OPC_OP32), addi(5, 0, 36),
             rtype(7'h00, 5, 2, 3'b001, 7, OPC_OP32),           // sllw uses low 5 bits
             sd(3, 'h400), sd(4, 'h408), sd(7, 'h410), EBREAK};
    hold_reset_and_load();
    release_reset();
    wait_for_halt();
    expect_write(0, 32'h400, 8'hff, 64'hffff_ffff_8000_0001);
    expect_write(1, 32'h408, 8'hff, 64'hffff_ffff_ffff_fffc);
    expect_write(2, 32'h410, 8'hff, 64'hffff_ffff_ffff_ffe0);
    check_counts(3, 11);
  endtask

  task automatic test_mem_sizes();
    prog = '{addi(1, 0, 'h600), itype(4, 1, 3'b010, 2, OPC_LOAD),
             itype(3, 1, 3'b100, 3, OPC_LOAD), itype(0, 1, 3'b011, 4, OPC_LOAD),
             sd(2, 'h400), sd(3, 'h408), sd(4, 'h410),
             stype('h41a, 4, 0, 3'b001), stype('h41e, 4, 0, 3'b001), EBREAK};
    hold_reset_and_load();
    i_mem.write_dword(32'h600, 64'h8123_4567_89ab_cdef);
    release_reset();
    wait_for_halt();
    expect_write(0, 32'h400, 8'hff, 64'hffff_ffff_8123_4567);   // lw sign-extends
    expect_write(1, 32'h408, 8'hff, 64'h89);                    // lbu zero-extends
    expect_write(2, 32'h410, 8'hff, 64'h8123_4567_89ab_cdef);
    expect_write(3, 32'h418, 8'h0c, 64'h0000_0000_cdef_0000);
    expect_write(4, 32'h418, 8'hc0, 64'hcdef_0000_0000_0000);
    check_counts(5, 10);
  endtask

  task automatic test_control();
    prog = '{addi(1, 0, 1), addi(2, 0, 2),
             btype(8, 2, 1, 3'b001),                             // taken and skips the next store
             sd(1, 'h400), btype(8, 1, 1, 3'b001), sd(2, 'h408),
             jtype(8, 4), sd(1, 'h410), addi(5, 0, 45),
             itype(3, 5, 3'b000, 6, OPC_JALR), sd(1, 'h418), sd(1, 'h420),
             sd(4, 'h428), sd(6, 'h430), EBREAK};
    hold_reset_and_load();
    release_reset();
    wait_for_halt();
    expect_write(0, 32'h408, 8'hff, 64'd2);
    expect_write(1, 32'h428, 8'hff, 64'd28);           // jal link
    expect_write(2, 32'h430, 8'hff, 64'd40);           // jalr link
    check_counts(3, 11);
  endtask

  task automatic test_halt();
    prog = '{addi(1, 0, 7), sd(1, 'h400), EBREAK, sd(1, 'h408)};
    hold_reset_and_load();
    release_reset();
    wait_for_halt();
    repeat (40) @(posedge clk);
    compare_halt(1'b1);
    expect_write(0, 32'h400, 8'hff, 64'd7);
    check_counts(1, 3);
    prog = '{addi(1, 0, 7), 32'hffff_ffff, sd(1, 'h400)};
    hold_reset_and_load();
    release_reset();
    compare_halt(1'b0);                                // cleared by reset
    wait_for_halt();
    repeat (40) @(posedge clk);
    compare_halt(1'b1);
    check_counts(0, 2);
  endtask

  initial begin
    void'($urandom(32'h4bfdde27));
    clk       = 1'b0;
    arst_n    = 1'b0;
    fetch_cnt = 0;
    test_arith();
    test_wforms();
    test_mem_sizes();
    test_control();
    test_halt();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- vlog.f
src/core_pkg.sv
src/inst_fetch.sv
src/inst_decode.sv
src/reg_file.sv
src/exec_unit.sv
src/load_store.sv
src/rv_core_top.sv
tests/wb_mem_model.sv
tests/rv_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
RTL_TOP   ?= rv_core_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
